//--- verilog/if_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Fetch stage definitions: queue and bus sizes, redirect selector,
// compressed and major opcode enums, reset instruction
////////////////////////////////////////////////////////////////////////////

package if_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int FIFO_DEPTH      = 2;   // Words held in the prefetch queue
  localparam int MAX_OUTSTANDING = 2;   // Granted requests still waiting for rvalid

  // Counter width, big enough for both the queue fill and the bus txn count
  localparam int CNT_W = $clog2(((FIFO_DEPTH > MAX_OUTSTANDING) ?
                                 FIFO_DEPTH : MAX_OUTSTANDING) + 1);

  localparam int IRQ_ID_W = 5;          // Interrupt index used for vectoring
  localparam int MTVEC_W  = 25;         // mtvec base, 128-byte aligned

  // addi x0, x0, 0
  localparam logic [31:0] INSTR_NOP = 32'h0000_0013;

  ////////////////////////////////////////////////////////////////////////////
  // Enums
  ////////////////////////////////////////////////////////////////////////////

  // Redirect sources for the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5,
    PC_TRAP_DBG = 3'd6
  } pc_mux_e;

  // Compressed forms known to the decoder
  typedef enum logic [2:0] {
    C_ADDI,
    C_LI,
    C_MV,
    C_ADD,
    C_J,
    C_LWSP,
    C_ILLEGAL
  } c_op_e;

  // Major opcodes of the expanded 32-bit encodings
  typedef enum logic [6:0] {
    OPC_LOAD   = 7'b0000011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011,
    OPC_JAL    = 7'b1101111
  } opcode_e;

endpackage

//--- verilog/instr_bus_if.sv
////////////////////////////////////////////////////////////////////////////
// Instruction bus master: req/gnt/rvalid handshake, outstanding
// transaction count, discard of responses made stale by a redirect
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module instr_bus_if import if_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  input  logic        fetch_valid_i,   // Prefetcher wants a word
  input  logic [31:0] fetch_addr_i,    // Word aligned
  input  logic        branch_i,        // Redirect, all owed responses become stale
  output logic        fetch_ready_o,   // Grant for the current stream
  output logic        resp_valid_o,
  output logic [31:0] resp_rdata_o,

  output logic        instr_req_o,
  output logic [31:0] instr_addr_o,
  input  logic        instr_gnt_i,
  input  logic        instr_rvalid_i,
  input  logic [31:0] instr_rdata_i
);

  logic [CNT_W-1:0] outstanding_q;   // Granted, no rvalid yet
  logic [CNT_W-1:0] outstanding_n;
  logic [CNT_W-1:0] discard_q;       // Responses still to be swallowed
  logic             hold_q;          // Request raised but not yet granted
  logic             stale_q;         // Held request belongs to an old stream
  logic [31:0]      hold_addr_q;
  logic             accept;
  logic             discard_hit;

  // New requests only with no stale data pending and room on the bus
  assign instr_req_o  = hold_q ||
                        (fetch_valid_i && (discard_q == '0) &&
                         (outstanding_q < CNT_W'(MAX_OUTSTANDING)));
  assign instr_addr_o = hold_q ? hold_addr_q : fetch_addr_i;  // Frozen until granted

  assign accept        = instr_req_o && instr_gnt_i;
  assign fetch_ready_o = accept && !stale_q;
  assign discard_hit   = instr_rvalid_i && (discard_q != '0);

  assign resp_valid_o = instr_rvalid_i && (discard_q == '0);
  assign resp_rdata_o = instr_rdata_i;

  assign outstanding_n = outstanding_q + CNT_W'(accept) - CNT_W'(instr_rvalid_i);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
      discard_q     <= '0;
      hold_q        <= 1'b0;
      stale_q       <= 1'b0;
    end else begin
      outstanding_q <= outstanding_n;
      hold_q        <= instr_req_o && !instr_gnt_i;
      // A redirect during a wait marks the held request stale
      stale_q       <= instr_req_o && !instr_gnt_i && (stale_q || branch_i);
      if (branch_i) begin
        discard_q <= outstanding_n;   // Everything still owed is old
      end else begin
        discard_q <= discard_q - CNT_W'(discard_hit) + CNT_W'(accept && stale_q);
      end
    end
  end

  // Address capture when a request first goes out
  always_ff @(posedge clk) begin
    if (instr_req_o && !hold_q) begin
      hold_addr_q <= fetch_addr_i;
    end
  end

endmodule

//--- verilog/prefetch_unit.sv
////////////////////////////////////////////////////////////////////////////
// Prefetcher: next word address, word queue, and halfword aligner
// that offers one instruction with its pc at a time
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module prefetch_unit import if_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,

  input  logic        branch_i,        // Flush and restart at branch_addr_i
  input  logic [31:0] branch_addr_i,   // Halfword aligned target
  input  logic        ready_i,         // Consume the offered instruction

  output logic        valid_o,
  output logic [31:0] instr_o,         // Upper half zero for compressed
  output logic [31:0] addr_o,

  output logic        fetch_valid_o,
  output logic [31:0] fetch_addr_o,
  input  logic        fetch_ready_i,
  input  logic        resp_valid_i,
  input  logic [31:0] resp_rdata_i,

  output logic        busy_o
);

  logic [31:0]      fetch_addr_q;      // Next word to request
  logic             active_q;          // Low until the first redirect
  logic [CNT_W-1:0] pending_q;         // Granted fetches of this stream
  logic [31:0]      q_data [FIFO_DEPTH];
  logic [CNT_W-1:0] q_cnt;
  logic [CNT_W-1:0] wr_idx;
  logic [31:0]      pc_q;

  logic             push;
  logic             pop;
  logic             consume;
  logic             is_comp;
  logic [15:0]      lo_half;
  logic [15:0]      hi_half;

  ////////////////////////////////////////////////////////////////////////////
  // Fetch side
  ////////////////////////////////////////////////////////////////////////////

  // Request only while queue plus in-flight words leave a free slot
  assign fetch_valid_o = active_q && ((q_cnt + pending_q) < CNT_W'(FIFO_DEPTH));
  assign fetch_addr_o  = fetch_addr_q;
  assign busy_o        = fetch_valid_o || (pending_q != '0);

  assign push = resp_valid_i && !branch_i;

  ////////////////////////////////////////////////////////////////////////////
  // Aligner
  ////////////////////////////////////////////////////////////////////////////

  // pc_q[1] selects the upper half of the head word
  assign lo_half = pc_q[1] ? q_data[0][31:16] : q_data[0][15:0];
  assign hi_half = pc_q[1] ? q_data[1][15:0]  : q_data[0][31:16];
  assign is_comp = (lo_half[1:0] != 2'b11);

  // A straddling 32-bit instruction needs the next word too
  assign valid_o = (q_cnt != '0) &&
                   (is_comp || !pc_q[1] || (q_cnt >= CNT_W'(2)));
  assign instr_o = is_comp ? {16'h0000, lo_half} : {hi_half, lo_half};
  assign addr_o  = pc_q;

  assign consume = ready_i && valid_o && !branch_i;
  // Head word is used up unless a compressed instr sits in its lower half
  assign pop     = consume && (pc_q[1] || !is_comp);
  assign wr_idx  = q_cnt - CNT_W'(pop);

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      active_q     <= 1'b0;
      fetch_addr_q <= '0;
      pending_q    <= '0;
      q_cnt        <= '0;
      pc_q         <= '0;
    end else if (branch_i) begin
      active_q     <= 1'b1;
      fetch_addr_q <= {branch_addr_i[31:2], 2'b00};
      pending_q    <= '0;                      // Bus side drops the old ones
      q_cnt        <= '0;
      pc_q         <= {branch_addr_i[31:1], 1'b0};
    end else begin
      if (fetch_ready_i) begin
        fetch_addr_q <= fetch_addr_q + 32'd4;
      end
      pending_q <= pending_q + CNT_W'(fetch_ready_i) - CNT_W'(resp_valid_i);
      q_cnt     <= q_cnt + CNT_W'(push) - CNT_W'(pop);
      if (consume) begin
        pc_q <= pc_q + (is_comp ? 32'd2 : 32'd4);
      end
    end
  end

  // Shift queue, head at index 0
  always_ff @(posedge clk) begin
    for (int i = 0; i < FIFO_DEPTH; i++) begin
      if (push && (i == int'(wr_idx))) begin
        q_data[i] <= resp_rdata_i;
      end else if (pop && (i < FIFO_DEPTH - 1)) begin
        q_data[i] <= q_data[(i + 1) % FIFO_DEPTH];
      end
    end
  end

endmodule

//--- verilog/compressed_decoder.sv
////////////////////////////////////////////////////////////////////////////
// Compressed decoder: expands C.ADDI, C.LI, C.MV, C.ADD, C.J and
// C.LWSP, passes 32-bit encodings, flags other compressed forms
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module compressed_decoder import if_pkg::*; (
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);

  logic [15:0] c;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [11:0] imm6;        // Sign extended CI immediate
  c_op_e       c_op;

  assign c    = instr_i[15:0];
  assign rd   = c[11:7];
  assign rs2  = c[6:2];
  assign imm6 = {{6{c[12]}}, c[12], c[6:2]};

  assign is_compressed_o = (c[1:0] != 2'b11);
  assign illegal_o       = is_compressed_o && (c_op == C_ILLEGAL);

  ////////////////////////////////////////////////////////////////////////////
  // Classify by quadrant and funct3
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    c_op = C_ILLEGAL;
    case (c[1:0])
      2'b01: begin
        case (c[15:13])
          3'b000:  c_op = C_ADDI;
          3'b010:  c_op = C_LI;
          3'b101:  c_op = C_J;
          default: c_op = C_ILLEGAL;
        endcase
      end
      2'b10: begin
        if (c[15:13] == 3'b100 && rs2 != 5'd0) begin
          c_op = c[12] ? C_ADD : C_MV;   // rs2 of zero is JR/JALR/EBREAK
        end else if (c[15:13] == 3'b010 && rd != 5'd0) begin
          c_op = C_LWSP;                 // rd of zero is reserved
        end
      end
      default: c_op = C_ILLEGAL;         // Quadrant 0 not supported
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Expansion
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    if (!is_compressed_o) begin
      instr_o = instr_i;                 // Full-width instr passes through
    end else begin
      case (c_op)
        C_ADDI:  instr_o = {imm6, rd, 3'b000, rd, OPC_OP_IMM};
        C_LI:    instr_o = {imm6, 5'd0, 3'b000, rd, OPC_OP_IMM};
        C_MV:    instr_o = {7'b0, rs2, 5'd0, 3'b000, rd, OPC_OP};
        C_ADD:   instr_o = {7'b0, rs2, rd, 3'b000, rd, OPC_OP};
        // jal x0, imm[20|10:1|11|19:12] from the CJ offset bits
        C_J:     instr_o = {c[12], c[8], c[10:9], c[6], c[7], c[2], c[11], c[5:3],
                            c[12], {8{c[12]}}, 5'd0, OPC_JAL};
        // lw rd, uimm(sp), offset bits 7:6 from c[3:2]
        C_LWSP:  instr_o = {4'b0, c[3:2], c[12], c[6:4], 2'b00, 5'd2, 3'b010, rd,
                            OPC_LOAD};
        default: instr_o = INSTR_NOP;
      endcase
    end
  end

endmodule

//--- verilog/if_stage.sv
////////////////////////////////////////////////////////////////////////////
// Fetch stage top: redirect address mux, mtvec init, stage handshake,
// IF/ID pipeline register, prefetcher, bus master and decoder
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module if_stage import if_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,

  // Controller
  input  logic                pc_set_i,           // One-cycle redirect strobe
  input  pc_mux_e             pc_mux_i,
  input  logic [IRQ_ID_W-1:0] irq_id_i,
  input  logic                kill_if_i,
  input  logic                halt_if_i,

  // Redirect targets
  input  logic [31:0]         boot_addr_i,
  input  logic [31:0]         jump_target_i,
  input  logic [31:0]         branch_target_i,
  input  logic [31:0]         mepc_i,
  input  logic [MTVEC_W-1:0]  mtvec_addr_i,       // Upper bits of mtvec
  input  logic [31:0]         dm_halt_addr_i,

  // Instruction bus
  output logic                instr_req_o,
  output logic [31:0]         instr_addr_o,
  input  logic                instr_gnt_i,
  input  logic                instr_rvalid_i,
  input  logic [31:0]         instr_rdata_i,

  // IF/ID pipeline register
  output logic                pipe_valid_o,
  output logic [31:0]         pipe_instr_o,       // Expanded encoding
  output logic [31:0]         pipe_pc_o,
  output logic                pipe_compressed_o,
  output logic                pipe_illegal_o,
  output logic [31:0]         pipe_raw_o,         // As fetched

  output logic [31:0]         pc_if_o,
  output logic                if_valid_o,
  input  logic                id_ready_i,
  output logic                if_busy_o,
  output logic                csr_mtvec_init_o
);

  logic [31:0] branch_addr;
  logic        branch;
  logic        if_ready;
  logic        pf_valid;
  logic [31:0] pf_instr;
  logic        pf_busy;
  logic        fetch_valid;
  logic [31:0] fetch_addr;
  logic        fetch_ready;
  logic        resp_valid;
  logic [31:0] resp_rdata;
  logic [31:0] dec_instr;
  logic        dec_compressed;
  logic        dec_illegal;

  ////////////////////////////////////////////////////////////////////////////
  // Next fetch address
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (pc_mux_i)
      PC_BOOT:     branch_addr = {boot_addr_i[31:2], 2'b00};
      PC_JUMP:     branch_addr = jump_target_i;
      PC_BRANCH:   branch_addr = branch_target_i;
      PC_MRET:     branch_addr = mepc_i;                         // Back to the trapped pc
      PC_TRAP_EXC: branch_addr = {mtvec_addr_i, 7'h00};          // Exceptions share the base
      PC_TRAP_IRQ: branch_addr = {mtvec_addr_i, irq_id_i, 2'b00}; // Base + 4 * id
      PC_TRAP_DBG: branch_addr = {dm_halt_addr_i[31:2], 2'b00};
      default:     branch_addr = {boot_addr_i[31:2], 2'b00};
    endcase
  end

  assign branch           = pc_set_i || kill_if_i;   // Kill flushes the queue too
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == PC_BOOT);

  // Stage handshake
  assign if_valid_o = pf_valid && !kill_if_i && !halt_if_i;
  assign if_ready   = kill_if_i || (id_ready_i && !halt_if_i);
  assign if_busy_o  = pf_busy;

  prefetch_unit i_prefetch (
    .clk           ( clk         ),
    .rst_n         ( rst_n       ),
    .branch_i      ( branch      ),
    .branch_addr_i ( branch_addr ),
    .ready_i       ( if_ready    ),
    .valid_o       ( pf_valid    ),
    .instr_o       ( pf_instr    ),
    .addr_o        ( pc_if_o     ),
    .fetch_valid_o ( fetch_valid ),
    .fetch_addr_o  ( fetch_addr  ),
    .fetch_ready_i ( fetch_ready ),
    .resp_valid_i  ( resp_valid  ),
    .resp_rdata_i  ( resp_rdata  ),
    .busy_o        ( pf_busy     )
  );

  instr_bus_if i_bus_if (
    .clk            ( clk            ),
    .rst_n          ( rst_n          ),
    .fetch_valid_i  ( fetch_valid    ),
    .fetch_addr_i   ( fetch_addr     ),
    .branch_i       ( branch         ),
    .fetch_ready_o  ( fetch_ready    ),
    .resp_valid_o   ( resp_valid     ),
    .resp_rdata_o   ( resp_rdata     ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  )
  );

  compressed_decoder i_decoder (
    .instr_i         ( pf_instr       ),
    .instr_o         ( dec_instr      ),
    .is_compressed_o ( dec_compressed ),
    .illegal_o       ( dec_illegal    )
  );

  ////////////////////////////////////////////////////////////////////////////
  // IF/ID pipeline register, frozen while ID stalls
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk, negedge rst_n) begin
    if (!rst_n) begin
      pipe_valid_o      <= 1'b0;
      pipe_instr_o      <= INSTR_NOP;
      pipe_pc_o         <= '0;
      pipe_compressed_o <= 1'b0;
      pipe_illegal_o    <= 1'b0;
      pipe_raw_o        <= '0;
    end else if (if_valid_o && id_ready_i) begin
      pipe_valid_o      <= 1'b1;
      pipe_instr_o      <= dec_instr;
      pipe_pc_o         <= pc_if_o;
      pipe_compressed_o <= dec_compressed;
      pipe_illegal_o    <= dec_illegal;
      pipe_raw_o        <= pf_instr;
    end else if (id_ready_i) begin
      pipe_valid_o      <= 1'b0;   // ID took it, nothing new offered
    end
  end

endmodule

//--- sim/if_stage_props.sv
////////////////////////////////////////////////////////////////////////////
// Bus and IF/ID register assertions, bound to the fetch stage top
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module if_stage_props import if_pkg::*; (
  input logic        clk,
  input logic        rst_n,
  input logic        instr_req_o,
  input logic        instr_gnt_i,
  input logic [31:0] instr_addr_o,
  input logic        instr_rvalid_i,
  input logic        id_ready_i,
  input logic        pipe_valid_o,
  input logic [31:0] pipe_instr_o,
  input logic [31:0] pipe_pc_o,
  input logic [31:0] pipe_raw_o
);

  int txn_cnt;   // Granted requests still owed a response

  always @(posedge clk, negedge rst_n) begin
    if (!rst_n) txn_cnt <= 0;
    else txn_cnt <= txn_cnt + int'(instr_req_o && instr_gnt_i) - int'(instr_rvalid_i);
  end

  // Request and address frozen until granted
  a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instr_addr_o changed while waiting for a grant");

  a_outstanding: assert property (@(posedge clk) disable iff (!rst_n)
    txn_cnt <= MAX_OUTSTANDING)
    else $error("too many outstanding bus requests");

  a_reset_valid: assert property (@(posedge clk) !rst_n |-> !pipe_valid_o)
    else $error("pipe_valid_o high during reset");

  a_pipe_hold: assert property (@(posedge clk) disable iff (!rst_n)
    !id_ready_i |=> $stable(pipe_instr_o) && $stable(pipe_pc_o) && $stable(pipe_raw_o))
    else $error("pipeline fields changed while ID stalled");

endmodule

//--- sim/if_checker.sv
////////////////////////////////////////////////////////////////////////////
// Checker: redirect targets, expansion, sequential stream against memory
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module if_checker import if_pkg::*; (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] mem_i [64],
  input  logic        pc_set_i,
  input  pc_mux_e     pc_mux_i,
  input  logic        csr_mtvec_init_i,
  input  logic        if_valid_i,
  input  logic        if_busy_i,
  input  logic [31:0] pc_if_i,
  input  logic        id_ready_i,
  input  logic        pipe_valid_i,
  input  logic [31:0] pipe_instr_i,
  input  logic [31:0] pipe_pc_i,
  input  logic [31:0] pipe_raw_i,
  input  logic        pipe_compressed_i,
  input  logic        pipe_illegal_i,
  input  logic [79:0] name_i,
  input  logic [31:0] exp_pc_i,
  input  logic [31:0] exp_instr_i,
  input  logic        exp_illegal_i,
  input  logic        done_i,
  output int          seen_o,       // Instructions of the current row
  output int          errors_o
);

  logic        fire_q = 1'b0;     // Pipe loaded on the last edge
  logic        first_q = 1'b0;
  logic        active_q = 1'b0;
  logic        set_q = 1'b0;      // Redirect on the last edge
  logic [79:0] name_q;
  pc_mux_e     mux_q;
  logic [31:0] epc_q, einstr_q, next_pc_q;
  logic        eill_q;
  int          init_cnt = 0;      // mtvec init pulses in this row
  int          row_err = 0;
  int          rows = 0;
  int          rows_failed = 0;

  initial begin
    seen_o = 0;
    errors_o = 0;
  end

  function automatic logic [15:0] half_at(input logic [31:0] addr);
    return addr[1] ? mem_i[addr[7:2]][31:16] : mem_i[addr[7:2]][15:0];
  endfunction

  task automatic check_val(input string field, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("[FAIL] %0s %0s: expected %h, actual %h", name_q, field, exp, act);
      errors_o++;
      row_err++;
    end
  endtask

  task automatic flag_error(input string msg);
    $display("%0s at %0t", msg, $time);
    errors_o++;
    row_err++;
  endtask

  task automatic close_row();
    // One init pulse on a boot redirect, none on the others
    check_val("mtvec_init", (mux_q == PC_BOOT) ? 32'd1 : 32'd0, init_cnt);
    rows++;
    if (row_err != 0) rows_failed++;
    $display("%0s: %0d instructions, %0d errors", name_q, seen_o, row_err);
  endtask

  always @(posedge clk) begin
    logic [15:0] lo;
    logic [31:0] raw;
    logic        comp;
    if (fire_q) begin
      lo   = half_at(pipe_pc_i);
      comp = (lo[1:0] != 2'b11);
      raw  = comp ? {16'h0000, lo} : {half_at(pipe_pc_i + 32'd2), lo};
      check_val("pipe_valid", 32'd1, {31'd0, pipe_valid_i});
      check_val("pc", first_q ? epc_q : next_pc_q, pipe_pc_i);
      if (first_q) begin
        check_val("instr", einstr_q, pipe_instr_i);
        check_val("illegal", {31'd0, eill_q}, {31'd0, pipe_illegal_i});
      end
      check_val("raw", raw, pipe_raw_i);
      check_val("compressed", {31'd0, comp}, {31'd0, pipe_compressed_i});
      next_pc_q = pipe_pc_i + (comp ? 32'd2 : 32'd4);
      first_q   = 1'b0;
      seen_o++;
    end
    fire_q = rst_n && if_valid_i && id_ready_i;
    // Offered pc, one edge ahead of the register
    if (fire_q) begin
      check_val("pc_if", first_q ? epc_q : next_pc_q, pc_if_i);
    end
    if (set_q && !if_busy_i) begin
      flag_error("if_busy_o stayed low right after a redirect");
    end
    if (rst_n && rows == 0 && !active_q && if_busy_i) begin
      flag_error("if_busy_o went high before the first redirect");
    end
    set_q = rst_n && pc_set_i;
    if (pc_set_i) begin
      if (active_q) close_row();
      active_q = 1'b1;
      name_q   = name_i;
      mux_q    = pc_mux_i;
      epc_q    = exp_pc_i;
      einstr_q = exp_instr_i;
      eill_q   = exp_illegal_i;
      first_q  = 1'b1;
      init_cnt = 0;
      row_err  = 0;
      seen_o   = 0;
    end
    if (rst_n && csr_mtvec_init_i) init_cnt++;
    if (done_i && active_q) begin
      close_row();
      active_q = 1'b0;
      $display("%0d tests, %0d passed, %0d failed, %0d errors",
               rows, rows - rows_failed, rows_failed, errors_o);
    end
  end

endmodule

//--- sim/tb_if_stage.sv
////////////////////////////////////////////////////////////////////////////
// Testbench top: clock, reset, redirect table, instruction memory model
// with random grant delay, cycle limit and final verdict
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps

module tb_if_stage import if_pkg::*; ();

  localparam int N_ROWS = 10;

  logic clk = 1'b0;
  logic rst_n;
  logic pc_set_i, kill_if_i, halt_if_i, id_ready_i;
  pc_mux_e pc_mux_i;
  logic [IRQ_ID_W-1:0] irq_id_i;
  logic [31:0] boot_addr_i, jump_target_i, branch_target_i, mepc_i, dm_halt_addr_i;
  logic [MTVEC_W-1:0] mtvec_addr_i;
  logic instr_req_o, instr_gnt_i, instr_rvalid_i;
  logic [31:0] instr_addr_o, instr_rdata_i;
  logic pipe_valid_o, pipe_compressed_o, pipe_illegal_o;
  logic [31:0] pipe_instr_o, pipe_pc_o, pipe_raw_o, pc_if_o;
  logic if_valid_o, if_busy_o, csr_mtvec_init_o;

  logic [31:0] mem [64];        // Byte address bits 7:2 index the words
  logic        acc_q;           // Request accepted on the last edge
  logic [31:0] acc_addr_q;
  int          gnt_wait;        // Cycles left before the next grant
  integer      seed;
  int          cycles;
  int          limit;
  logic        done;
  int          seen;
  int          errors;

  // Redirect table
  logic [79:0] row_name [N_ROWS];
  pc_mux_e     row_mux [N_ROWS];
  logic [31:0] row_addr [N_ROWS];
  int          row_cnt [N_ROWS];
  logic [31:0] row_pc [N_ROWS];
  logic [31:0] row_instr [N_ROWS];
  logic        row_ill [N_ROWS];
  logic [7:0]  row_stall [N_ROWS];   // Bit k stalls ID in cycle k of 8
  int          r;

  always #2 clk = ~clk;

  if_stage i_dut (.*);

  if_checker i_checker (
    .clk               ( clk               ),
    .rst_n             ( rst_n             ),
    .mem_i             ( mem               ),
    .pc_set_i          ( pc_set_i          ),
    .pc_mux_i          ( pc_mux_i          ),
    .csr_mtvec_init_i  ( csr_mtvec_init_o  ),
    .if_valid_i        ( if_valid_o        ),
    .if_busy_i         ( if_busy_o         ),
    .pc_if_i           ( pc_if_o           ),
    .id_ready_i        ( id_ready_i        ),
    .pipe_valid_i      ( pipe_valid_o      ),
    .pipe_instr_i      ( pipe_instr_o      ),
    .pipe_pc_i         ( pipe_pc_o         ),
    .pipe_raw_i        ( pipe_raw_o        ),
    .pipe_compressed_i ( pipe_compressed_o ),
    .pipe_illegal_i    ( pipe_illegal_o    ),
    .name_i            ( row_name[r]       ),
    .exp_pc_i          ( row_pc[r]         ),
    .exp_instr_i       ( row_instr[r]      ),
    .exp_illegal_i     ( row_ill[r]        ),
    .done_i            ( done              ),
    .seen_o            ( seen              ),
    .errors_o          ( errors            )
  );

  bind if_stage if_stage_props i_props (
    .clk (clk), .rst_n (rst_n), .instr_req_o (instr_req_o), .instr_gnt_i (instr_gnt_i),
    .instr_addr_o (instr_addr_o), .instr_rvalid_i (instr_rvalid_i),
    .id_ready_i (id_ready_i), .pipe_valid_o (pipe_valid_o), .pipe_instr_o (pipe_instr_o),
    .pipe_pc_o (pipe_pc_o), .pipe_raw_o (pipe_raw_o)
  );

  task automatic add_row(input int idx, input logic [79:0] name, input pc_mux_e mux,
                         input logic [31:0] addr, input int cnt, input logic [31:0] epc,
                         input logic [31:0] einstr, input logic eill, input logic [7:0] stall);
    row_name[idx]  = name;
    row_mux[idx]   = mux;
    row_addr[idx]  = addr;
    row_cnt[idx]   = cnt;
    row_pc[idx]    = epc;
    row_instr[idx] = einstr;
    row_ill[idx]   = eill;
    row_stall[idx] = stall;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Memory model, grant after 0 to 2 cycles, rvalid one cycle after grant
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    acc_q      <= instr_req_o && instr_gnt_i;
    acc_addr_q <= instr_addr_o;
  end

  always @(negedge clk) begin
    instr_rvalid_i <= acc_q && rst_n;
    instr_rdata_i  <= mem[acc_addr_q[7:2]];
    if (instr_req_o && gnt_wait == 0) begin
      instr_gnt_i <= 1'b1;
      gnt_wait    <= int'($unsigned($random(seed)) % 3);
    end else begin
      instr_gnt_i <= 1'b0;
      if (instr_req_o) gnt_wait <= gnt_wait - 1;
    end
  end

  // Cycle limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("Timeout: the run went past its limit of %0d cycles", limit);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    seed            = 39;
    cycles          = 0;
    gnt_wait        = 0;
    r               = 0;
    done            = 1'b0;
    rst_n           = 1'b0;
    pc_set_i        = 1'b0;
    kill_if_i       = 1'b0;
    halt_if_i       = 1'b0;
    id_ready_i      = 1'b0;
    pc_mux_i        = PC_BOOT;
    irq_id_i        = 5'd3;
    mtvec_addr_i    = '0;
    boot_addr_i     = '0;
    jump_target_i   = '0;
    branch_target_i = '0;
    mepc_i          = '0;
    dm_halt_addr_i  = '0;
    instr_gnt_i     = 1'b0;
    instr_rvalid_i  = 1'b0;
    instr_rdata_i   = '0;
    // Fill: addi xi, xi, byte address
    for (int i = 0; i < 64; i++) begin
      mem[i] = {4'h0, 8'(i * 4), 5'(i), 3'b000, 5'(i), 7'h13};
    end
    mem[8'h10 >> 2] = 32'h0001_028D;   // c.addi x5,3 ; c.nop
    mem[8'h20 >> 2] = 32'h537D_0001;   // c.nop ; c.li x6,-1
    mem[8'h30 >> 2] = 32'h8093_83A2;   // c.mv x7,x8 ; low half of addi x1,x1,1
    mem[8'h34 >> 2] = 32'h94AA_0010;   // Upper half of addi ; c.add x9,x10
    mem[8'h40 >> 2] = 32'hA005_0001;   // c.nop ; c.j +32
    mem[8'h80 >> 2] = 32'h0001_45A2;   // c.lwsp x11,8(sp)
    mem[8'h8C >> 2] = 32'h0001_4000;   // Quadrant 0, not supported
    mem[8'hA0 >> 2] = 32'h00A0_0513;   // addi x10,x0,10
    add_row(0, "boot",     PC_BOOT,     32'h12, 4, 32'h10, 32'h0032_8293, 1'b0, 8'h00);
    add_row(1, "jump",     PC_JUMP,     32'h22, 3, 32'h22, 32'hFFF0_0313, 1'b0, 8'h00);
    add_row(2, "branch",   PC_BRANCH,   32'h30, 4, 32'h30, 32'h0080_03B3, 1'b0, 8'h00);
    add_row(3, "mret",     PC_MRET,     32'h42, 3, 32'h42, 32'h0200_006F, 1'b0, 8'h00);
    add_row(4, "trap_exc", PC_TRAP_EXC, 32'h01, 3, 32'h80, 32'h0081_2583, 1'b0, 8'h00);
    add_row(5, "trap_irq", PC_TRAP_IRQ, 32'h01, 3, 32'h8C, 32'h0000_0013, 1'b1, 8'h00);
    add_row(6, "trap_dbg", PC_TRAP_DBG, 32'hA3, 2, 32'hA0, 32'h00A0_0513, 1'b0, 8'h00);
    add_row(7, "stall",    PC_JUMP,     32'h30, 4, 32'h30, 32'h0080_03B3, 1'b0, 8'hB6);
    add_row(8, "inflight", PC_BRANCH,   32'h10, 1, 32'h10, 32'h0032_8293, 1'b0, 8'h00);
    add_row(9, "resume",   PC_MRET,     32'h22, 3, 32'h22, 32'hFFF0_0313, 1'b0, 8'h49);
    limit = 8;
    for (int i = 0; i < N_ROWS; i++) limit += 40 * row_cnt[i];

    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    for (int t = 0; t < N_ROWS; t++) begin
      @(negedge clk);
      r               = t;
      pc_set_i        = 1'b1;
      pc_mux_i        = row_mux[t];
      id_ready_i      = 1'b0;   // ID holds while redirecting
      halt_if_i       = 1'b0;
      boot_addr_i     = row_addr[t];
      jump_target_i   = row_addr[t];
      branch_target_i = row_addr[t];
      mepc_i          = row_addr[t];
      dm_halt_addr_i  = row_addr[t];
      mtvec_addr_i    = row_addr[t][MTVEC_W-1:0];
      @(negedge clk);
      pc_set_i = 1'b0;
      for (int k = 0; seen < row_cnt[t]; k++) begin
        id_ready_i = !row_stall[t][k % 8];
        halt_if_i  = row_stall[t][(k + 3) % 8];
        @(negedge clk);
      end
    end

    @(negedge clk);
    id_ready_i = 1'b0;
    done = 1'b1;
    @(negedge clk);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- flist.f
verilog/if_pkg.sv
verilog/instr_bus_if.sv
verilog/prefetch_unit.sv
verilog/compressed_decoder.sv
verilog/if_stage.sv
sim/if_stage_props.sv
sim/if_checker.sv
sim/tb_if_stage.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_if_stage
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
